//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // Register number width, the ISA fixes 32 registers
    parameter int REG_ADDR_W = 5;

    //////////////////////////////
    // Instruction encodings
    //////////////////////////////

    // Major opcode, bits 31:26
    typedef enum logic [5:0] {
        R_TYPE = 6'h00,
        ADDI   = 6'h08,
        ANDI   = 6'h0c,
        ORI    = 6'h0d
    } opcode_e;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_XOR = 6'h26,
        F_SLT = 6'h2a
    } funct_e;

    //////////////////////////////
    // Datapath controls
    //////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // Operand source, same codes as the forwarding mux select
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_e;

endpackage

`default_nettype wire

//--- rtl/pipe_ifs.sv
`timescale 1ns/100ps
`default_nettype none

// Decode to execute stage register contents
interface id_ex_if #(
    parameter int DATA_WIDTH = 32
);
    import mips_pkg::*;

    // Register numbers, rd already muxed with rt for I-type
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    // Operand values as read in decode
    logic [DATA_WIDTH-1:0] rs_val;
    logic [DATA_WIDTH-1:0] rt_val;
    logic [DATA_WIDTH-1:0] imm;
    // Controls
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  regwrite;

    modport producer (output rs, rt, rd, rs_val, rt_val, imm, alu_op, use_imm, regwrite);
    modport consumer (input rs, rt, rd, rs_val, rt_val, imm, alu_op, use_imm, regwrite);
endinterface

// Register file write port
interface wb_if #(
    parameter int DATA_WIDTH = 32
);
    import mips_pkg::*;

    logic                  we;
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_WIDTH-1:0] data;

    modport producer (output we, rd, data);
    modport consumer (input we, rd, data);
endinterface

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    // Wishbone classic, read only
    input  logic [DATA_WIDTH-1:0] i_wb_dat,
    input  logic                  i_wb_ack,
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic [ADDR_WIDTH-1:0] o_wb_adr,
    // To decode
    output logic [DATA_WIDTH-1:0] o_instr,
    output logic                  o_advance
);

    // Byte address of the word being requested
    logic [ADDR_WIDTH-1:0] pc;
    // Request active, cycle and strobe move together
    logic                  req;
    // Fetch to decode register
    logic [DATA_WIDTH-1:0] instr_q;

    //////////////////////////////
    // Bus master
    //////////////////////////////

    // Strobe stays up once out of reset, next word follows each ack
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            req <= 1'b0;
            pc  <= '0;
        end else begin
            req <= 1'b1;
            if (o_advance) begin
                pc <= pc + ADDR_WIDTH'(4);
            end
        end
    end

    // Ack only counts during an active cycle
    assign o_advance = req & i_wb_ack;

    assign o_wb_cyc = req;
    assign o_wb_stb = req;
    // Held until ack since pc only moves on advance
    assign o_wb_adr = pc;

    //////////////////////////////
    // IF/ID register
    //////////////////////////////

    // Word zero decodes as a no-op
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            instr_q <= '0;
        end else if (o_advance) begin
            instr_q <= i_wb_dat;
        end
    end

    assign o_instr = instr_q;

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_advance,
    input  logic [DATA_WIDTH-1:0] i_instr,
    id_ex_if.producer             id_ex,
    wb_if.consumer                wb
);
    import mips_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    // Instruction fields
    opcode_e               opcode;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rs_f;
    logic [REG_ADDR_W-1:0] rt_f;
    logic [REG_ADDR_W-1:0] rd_f;
    logic [15:0]           imm_f;

    // Decoded controls
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  regwrite;
    logic                  sign_ext;
    logic [REG_ADDR_W-1:0] dest;
    logic [DATA_WIDTH-1:0] imm_ext;

    // Register file storage
    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    assign opcode = opcode_e'(i_instr[31:26]);
    assign rs_f   = i_instr[25:21];
    assign rt_f   = i_instr[20:16];
    assign rd_f   = i_instr[15:11];
    assign funct  = funct_e'(i_instr[5:0]);
    assign imm_f  = i_instr[15:0];

    //////////////////////////////
    // Decoder
    //////////////////////////////

    always_comb begin
        // Anything not listed falls through as a no-op
        alu_op   = ALU_ADD;
        use_imm  = 1'b0;
        regwrite = 1'b0;
        sign_ext = 1'b0;
        dest     = rd_f;
        case (opcode)
            R_TYPE: begin
                regwrite = 1'b1;
                case (funct)
                    F_ADD:   alu_op = ALU_ADD;
                    F_SUB:   alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_XOR:   alu_op = ALU_XOR;
                    F_SLT:   alu_op = ALU_SLT;
                    default: regwrite = 1'b0;
                endcase
            end
            // I-type writes rt
            ADDI: begin
                use_imm  = 1'b1;
                regwrite = 1'b1;
                sign_ext = 1'b1;
                dest     = rt_f;
            end
            ANDI: begin
                alu_op   = ALU_AND;
                use_imm  = 1'b1;
                regwrite = 1'b1;
                dest     = rt_f;
            end
            ORI: begin
                alu_op   = ALU_OR;
                use_imm  = 1'b1;
                regwrite = 1'b1;
                dest     = rt_f;
            end
            default: ;
        endcase
    end

    // Sign extend for ADDI only, logic ops take zero extension
    assign imm_ext = sign_ext ? DATA_WIDTH'($signed(imm_f)) : DATA_WIDTH'(imm_f);

    //////////////////////////////
    // Register file
    //////////////////////////////

    // r0 never written
    always_ff @(posedge i_clk) begin
        if (wb.we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // r0 reads zero, same-cycle write passes straight through
    function automatic logic [DATA_WIDTH-1:0] read_reg(logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wb.we && (wb.rd == addr)) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    //////////////////////////////
    // ID/EX register
    //////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            id_ex.rs       <= '0;
            id_ex.rt       <= '0;
            id_ex.rd       <= '0;
            id_ex.rs_val   <= '0;
            id_ex.rt_val   <= '0;
            id_ex.imm      <= '0;
            id_ex.alu_op   <= ALU_ADD;
            id_ex.use_imm  <= 1'b0;
            id_ex.regwrite <= 1'b0;
        end else if (i_advance) begin
            id_ex.rs       <= rs_f;
            id_ex.rt       <= rt_f;
            id_ex.rd       <= dest;
            id_ex.rs_val   <= read_reg(rs_f);
            id_ex.rt_val   <= read_reg(rt_f);
            id_ex.imm      <= imm_ext;
            id_ex.alu_op   <= alu_op;
            id_ex.use_imm  <= use_imm;
            id_ex.regwrite <= regwrite;
        end
    end

endmodule

`default_nettype wire

//--- rtl/forwarding_unit.sv
`timescale 1ns/100ps
`default_nettype none

module forwarding_unit (
    // Sources of the instruction in execute
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rs,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rt,
    // Destinations one and two stages ahead
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rd_mem,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rd_wb,
    input  logic                            i_regwrite_mem,
    input  logic                            i_regwrite_wb,
    // Operand A and B select
    output mips_pkg::fwd_sel_e              o_fwd_a,
    output mips_pkg::fwd_sel_e              o_fwd_b
);
    import mips_pkg::*;

    // Hazard against a stage that writes a real register
    logic hit_mem_a;
    logic hit_mem_b;
    logic hit_wb_a;
    logic hit_wb_b;

    // EX hazard
    assign hit_mem_a = i_regwrite_mem && (i_rd_mem != '0) && (i_rd_mem == i_rs);
    assign hit_mem_b = i_regwrite_mem && (i_rd_mem != '0) && (i_rd_mem == i_rt);
    // MEM hazard
    assign hit_wb_a  = i_regwrite_wb && (i_rd_wb != '0) && (i_rd_wb == i_rs);
    assign hit_wb_b  = i_regwrite_wb && (i_rd_wb != '0) && (i_rd_wb == i_rt);

    // Newer result first, so a double hazard takes EX/MEM
    function automatic fwd_sel_e pick(logic hit_mem, logic hit_wb);
        if (hit_mem) begin
            return FWD_MEM;
        end else if (hit_wb) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign o_fwd_a = pick(hit_mem_a, hit_wb_a);
    assign o_fwd_b = pick(hit_mem_b, hit_wb_b);

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage #(
    parameter int DATA_WIDTH = 32
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_advance,
    id_ex_if.consumer id_ex,
    wb_if.producer    wb
);
    import mips_pkg::*;

    // Forwarding selects
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
    // ALU inputs and output
    logic [DATA_WIDTH-1:0] op_a;
    logic [DATA_WIDTH-1:0] rt_fwd;
    logic [DATA_WIDTH-1:0] op_b;
    logic [DATA_WIDTH-1:0] alu_result;

    // EX/MEM register
    logic [DATA_WIDTH-1:0] ex_mem_result;
    logic [REG_ADDR_W-1:0] ex_mem_rd;
    logic                  ex_mem_regwrite;
    // MEM/WB register
    logic [DATA_WIDTH-1:0] mem_wb_data;
    logic [REG_ADDR_W-1:0] mem_wb_rd;
    logic                  mem_wb_regwrite;
    // One cycle write pulse per advance
    logic                  mem_wb_we;

    forwarding_unit forwarding_unit_i (
        .i_rs           (id_ex.rs),
        .i_rt           (id_ex.rt),
        .i_rd_mem       (ex_mem_rd),
        .i_rd_wb        (mem_wb_rd),
        .i_regwrite_mem (ex_mem_regwrite),
        .i_regwrite_wb  (mem_wb_regwrite),
        .o_fwd_a        (fwd_a),
        .o_fwd_b        (fwd_b)
    );

    //////////////////////////////
    // Operand muxes
    //////////////////////////////

    function automatic logic [DATA_WIDTH-1:0] fwd_mux(fwd_sel_e sel,
                                                      logic [DATA_WIDTH-1:0] reg_val);
        case (sel)
            FWD_MEM: return ex_mem_result;
            FWD_WB:  return mem_wb_data;
            default: return reg_val;
        endcase
    endfunction

    assign op_a   = fwd_mux(fwd_a, id_ex.rs_val);
    assign rt_fwd = fwd_mux(fwd_b, id_ex.rt_val);
    // Immediate replaces B after forwarding
    assign op_b   = id_ex.use_imm ? id_ex.imm : rt_fwd;

    //////////////////////////////
    // ALU
    //////////////////////////////

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            // Signed compare
            ALU_SLT: alu_result = DATA_WIDTH'($signed(op_a) < $signed(op_b));
            default: alu_result = '0;
        endcase
    end

    //////////////////////////////
    // EX/MEM and MEM/WB
    //////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ex_mem_result   <= '0;
            ex_mem_rd       <= '0;
            ex_mem_regwrite <= 1'b0;
            mem_wb_data     <= '0;
            mem_wb_rd       <= '0;
            mem_wb_regwrite <= 1'b0;
            mem_wb_we       <= 1'b0;
        end else begin
            // Held bit feeds forwarding, pulse feeds the register file
            mem_wb_we <= i_advance & ex_mem_regwrite;
            if (i_advance) begin
                ex_mem_result   <= alu_result;
                ex_mem_rd       <= id_ex.rd;
                ex_mem_regwrite <= id_ex.regwrite;
                // No data memory, MEM stage just passes through
                mem_wb_data     <= ex_mem_result;
                mem_wb_rd       <= ex_mem_rd;
                mem_wb_regwrite <= ex_mem_regwrite;
            end
        end
    end

    assign wb.we   = mem_wb_we;
    assign wb.rd   = mem_wb_rd;
    assign wb.data = mem_wb_data;

endmodule

`default_nettype wire

//--- rtl/pipeline_core.sv
`timescale 1ns/100ps
`default_nettype none

module pipeline_core #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 16
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    // Instruction fetch, Wishbone classic
    input  logic [DATA_WIDTH-1:0]           i_wb_dat,
    input  logic                            i_wb_ack,
    output logic                            o_wb_cyc,
    output logic                            o_wb_stb,
    output logic [ADDR_WIDTH-1:0]           o_wb_adr,
    // Register file write, for observation
    output logic                            o_rf_we,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_rf_addr,
    output logic [DATA_WIDTH-1:0]           o_rf_data
);

    // Pipeline step, every stage register loads on it
    logic                  advance;
    // IF/ID instruction
    logic [DATA_WIDTH-1:0] instr;

    id_ex_if #(.DATA_WIDTH(DATA_WIDTH)) id_ex_bus ();
    wb_if    #(.DATA_WIDTH(DATA_WIDTH)) wb_bus ();

    fetch_stage #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) fetch_stage_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wb_dat  (i_wb_dat),
        .i_wb_ack  (i_wb_ack),
        .o_wb_cyc  (o_wb_cyc),
        .o_wb_stb  (o_wb_stb),
        .o_wb_adr  (o_wb_adr),
        .o_instr   (instr),
        .o_advance (advance)
    );

    decode_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) decode_stage_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_advance (advance),
        .i_instr   (instr),
        .id_ex     (id_ex_bus.producer),
        .wb        (wb_bus.consumer)
    );

    execute_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) execute_stage_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_advance (advance),
        .id_ex     (id_ex_bus.consumer),
        .wb        (wb_bus.producer)
    );

    // Write-back port straight out
    assign o_rf_we   = wb_bus.we;
    assign o_rf_addr = wb_bus.rd;
    assign o_rf_data = wb_bus.data;

endmodule

`default_nettype wire

//--- verification/core_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module core_asserts #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 16
) (
    input logic                            i_clk,
    input logic                            i_rst_n,
    input logic                            i_wb_cyc,
    input logic                            i_wb_stb,
    input logic [ADDR_WIDTH-1:0]           i_wb_adr,
    input logic                            i_wb_ack,
    input logic                            i_rf_we,
    input logic [mips_pkg::REG_ADDR_W-1:0] i_rf_addr,
    input logic [DATA_WIDTH-1:0]           i_rf_data
);

    // Wishbone classic master rules
    stb_within_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_stb |-> i_wb_cyc)
        else $error("Wishbone strobe high without cycle");

    adr_held_in_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_stb && !i_wb_ack) |=> $stable(i_wb_adr))
        else $error("Wishbone address changed during a wait state");

    // Write-back port
    wb_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown({i_rf_we, i_rf_addr, i_rf_data}))
        else $error("Write-back port carries unknown bits");

    // Write pulse comes from one advance only
    we_single_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rf_we && !i_wb_ack) |=> !i_rf_we)
        else $error("Register write held without an advance");

endmodule

bind pipeline_core core_asserts #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
) core_asserts_i (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_wb_cyc  (o_wb_cyc),
    .i_wb_stb  (o_wb_stb),
    .i_wb_adr  (o_wb_adr),
    .i_wb_ack  (i_wb_ack),
    .i_rf_we   (o_rf_we),
    .i_rf_addr (o_rf_addr),
    .i_rf_data (o_rf_data)
);

`default_nettype wire

//--- verification/core_checker.sv
`timescale 1ns/100ps
`default_nettype none

module core_checker #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    // Observed write-back port
    input  logic                            i_rf_we,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rf_addr,
    input  logic [DATA_WIDTH-1:0]           i_rf_data,
    // Program drained
    input  logic                            i_done,
    output logic                            o_finished,
    output int                              o_checks,
    output int                              o_errors
);
    import mips_pkg::*;

    // Expected writes in program order
    logic [REG_ADDR_W-1:0] exp_reg  [$];
    logic [DATA_WIDTH-1:0] exp_val  [$];
    int                    exp_test [$];
    // Running counts for the current test
    int                    test_checks;
    int                    test_errors;

    task automatic add_expected(input logic [REG_ADDR_W-1:0] reg_num,
                                input logic [DATA_WIDTH-1:0] value,
                                input int                    test_num);
        exp_reg.push_back(reg_num);
        exp_val.push_back(value);
        exp_test.push_back(test_num);
    endtask

    task automatic check_write();
        logic [REG_ADDR_W-1:0] reg_num;
        logic [DATA_WIDTH-1:0] value;
        int                    test_num;
        if (exp_reg.size() == 0) begin
            $display("Unexpected write at %0t: r%0d written with %h after the last expected write",
                     $time, i_rf_addr, i_rf_data);
            o_errors++;
        end else begin
            reg_num  = exp_reg.pop_front();
            value    = exp_val.pop_front();
            test_num = exp_test.pop_front();
            o_checks++;
            test_checks++;
            if (i_rf_addr !== reg_num || i_rf_data !== value) begin
                $display("Mismatch at %0t: test %0d expected r%0d = %h, got r%0d = %h",
                         $time, test_num, reg_num, value, i_rf_addr, i_rf_data);
                o_errors++;
                test_errors++;
            end
            // Last write of a section closes that test
            if (exp_test.size() == 0 || exp_test[0] != test_num) begin
                $display("Test %0d finished: %0d writes checked, %0d errors",
                         test_num, test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end
    endtask

    //////////////////////////////
    // Compare at the falling edge
    //////////////////////////////

    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            o_finished  = 1'b0;
            o_checks    = 0;
            o_errors    = 0;
            test_checks = 0;
            test_errors = 0;
        end else if (!o_finished) begin
            // Writes to r0 are dropped by the core
            if (i_rf_we === 1'b1 && i_rf_addr != '0) begin
                check_write();
            end
            if (i_done) begin
                if (exp_reg.size() != 0) begin
                    $display("Program ended with %0d expected writes never seen, next is r%0d",
                             exp_reg.size(), exp_reg[0]);
                    o_errors = o_errors + exp_reg.size();
                end
                o_finished = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module core_tb;
    import mips_pkg::*;

    localparam int          DATA_WIDTH  = 32;
    localparam int          ADDR_WIDTH  = 16;
    localparam int          CLK_PERIOD  = 100;
    localparam int          DRIVE_DELAY = 1;
    localparam logic [15:0] LFSR_SEED   = 16'd44213;
    // Galois feedback taps, maximal length for 16 bits
    localparam logic [15:0] LFSR_TAPS   = 16'hb400;

    // DUT ports
    logic                  clk;
    logic                  rst_n;
    logic [DATA_WIDTH-1:0] wb_dat;
    logic                  wb_ack;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic [ADDR_WIDTH-1:0] wb_adr;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_addr;
    logic [DATA_WIDTH-1:0] rf_data;

    // Checker handshake and counts
    logic                  done;
    logic                  finished;
    int                    checks;
    int                    errors;

    // Instruction memory, one word per I line
    logic [DATA_WIDTH-1:0] program_words [$];
    int                    load_errors;
    int                    acks;
    int                    cycles;
    int                    cycle_limit;
    // Wait state generator
    logic [15:0]           lfsr;
    int                    wait_left;
    logic                  new_request;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pipeline_core #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) pipeline_core_i (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_wb_dat  (wb_dat),
        .i_wb_ack  (wb_ack),
        .o_wb_cyc  (wb_cyc),
        .o_wb_stb  (wb_stb),
        .o_wb_adr  (wb_adr),
        .o_rf_we   (rf_we),
        .o_rf_addr (rf_addr),
        .o_rf_data (rf_data)
    );

    core_checker #(
        .DATA_WIDTH (DATA_WIDTH)
    ) core_checker_i (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_rf_we    (rf_we),
        .i_rf_addr  (rf_addr),
        .i_rf_data  (rf_data),
        .i_done     (done),
        .o_finished (finished),
        .o_checks   (checks),
        .o_errors   (errors)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // Two LFSR bits, one step each, give 0 to 3 wait cycles
    task automatic draw_wait_count(output int count);
        count = 0;
        repeat (2) begin
            count = (count << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    // Past the end of the program the bus returns no-ops
    function automatic logic [DATA_WIDTH-1:0] read_word(input logic [ADDR_WIDTH-1:0] adr);
        int idx;
        idx = int'(adr >> 2);
        if (idx < program_words.size()) begin
            return program_words[idx];
        end
        return '0;
    endfunction

    // Token based reader, comment lines start with //
    task automatic load_golden();
        int                    fd;
        int                    n;
        int                    test_num;
        int                    num_writes;
        logic [31:0]           tag;
        logic [DATA_WIDTH-1:0] word;
        logic [REG_ADDR_W-1:0] reg_num;
        logic [8*256-1:0]      rest;
        num_writes = 0;
        fd = $fopen("verification/core_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file verification/core_golden.txt");
            load_errors++;
        end else begin
            while (!$feof(fd)) begin
                tag = '0;
                n   = $fscanf(fd, "%s", tag);
                if (n == 1) begin
                    if (tag == "I") begin
                        n = $fscanf(fd, "%h", word);
                        program_words.push_back(word);
                    end else if (tag == "W") begin
                        n = $fscanf(fd, "%h %h %d", reg_num, word, test_num);
                        core_checker_i.add_expected(reg_num, word, test_num);
                        num_writes++;
                    end else if (tag == "//") begin
                        n = $fgets(rest, fd);
                    end else begin
                        $display("Golden file holds a line of unknown type");
                        load_errors++;
                        n = $fgets(rest, fd);
                    end
                end
            end
            $fclose(fd);
            if (program_words.size() == 0 || num_writes == 0) begin
                $display("Golden file holds no program or no expected writes");
                load_errors++;
            end
        end
    endtask

    //////////////////////////////
    // Wishbone instruction memory
    //////////////////////////////

    // Ack seen high at an edge has been taken by the core
    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (!rst_n) begin
            wb_ack      = 1'b0;
            wb_dat      = '0;
            new_request = 1'b1;
        end else begin
            if (wb_ack) begin
                wb_ack      = 1'b0;
                acks        = acks + 1;
                new_request = 1'b1;
            end
            if (wb_stb) begin
                if (new_request) begin
                    draw_wait_count(wait_left);
                    new_request = 1'b0;
                end
                if (wait_left == 0) begin
                    wb_ack = 1'b1;
                    wb_dat = read_word(wb_adr);
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    //////////////////////////////
    // Run control
    //////////////////////////////

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("Timeout: program not finished within %0d cycles", cycle_limit);
        $display("Regression failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        wb_dat      = '0;
        wb_ack      = 1'b0;
        done        = 1'b0;
        load_errors = 0;
        acks        = 0;
        cycles      = 0;
        cycle_limit = 0;
        wait_left   = 0;
        new_request = 1'b1;
        lfsr        = LFSR_SEED;
        load_golden();
        if (load_errors == 0) begin
            // Worst case four cycles per fetch, plus margin
            cycle_limit = program_words.size() * 6 + 20;
            repeat (3) @(posedge clk);
            #DRIVE_DELAY;
            rst_n = 1'b1;
            // One advance past the last word drains the final write
            wait (acks > program_words.size());
            done = 1'b1;
            wait (finished === 1'b1);
        end
        $display("Summary: %0d writes checked, %0d errors", checks, errors + load_errors);
        if (errors == 0 && load_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/mips_pkg.sv
rtl/pipe_ifs.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/forwarding_unit.sv
rtl/execute_stage.sv
rtl/pipeline_core.sv
verification/core_asserts.sv
verification/core_checker.sv
verification/core_tb.sv

//--- Bender.yml
package:
  name: pipeline_core

sources:
  - files:
      - rtl/mips_pkg.sv
      - rtl/pipe_ifs.sv
      - rtl/fetch_stage.sv
      - rtl/decode_stage.sv
      - rtl/forwarding_unit.sv
      - rtl/execute_stage.sv
      - rtl/pipeline_core.sv
  - target: test
    files:
      - verification/core_asserts.sv
      - verification/core_checker.sv
      - verification/core_tb.sv

//--- verification/core_golden.txt
// I <instruction word hex>, fetched in order from address 0
// W <register hex> <value hex> <test number>, expected writes in program order
// Test 1, independent ALU operations
I 20010005
W 01 00000005 1
I 2002FFFD
W 02 FFFFFFFD 1
I 00000000
I 00000000
I 00000000
I 00221820
W 03 00000002 1
I 00000000
I 00222022
W 04 00000008 1
I 00000000
I 00222824
W 05 00000005 1
I 00000000
I 00223025
W 06 FFFFFFFD 1
I 00000000
I 00223826
W 07 FFFFFFF8 1
I 00000000
I 0041402A
W 08 00000001 1
I 00000000
I 0022482A
W 09 00000000 1
I 00000000
I 342A8000
W 0a 00008005 1
I 00000000
I 304BFFF0
W 0b 0000FFF0 1
I 00000000
I 202CFFF0
W 0c FFFFFFF5 1
// Test 2, distance 1 on rs, on rt and on both
I 200D0010
W 0d 00000010 2
I 01A07020
W 0e 00000010 2
I 000E7822
W 0f FFFFFFF0 2
I 01EF8020
W 10 FFFFFFE0 2
// Test 3, distance 2 then distance 3
I 34111234
W 11 00001234 3
I 00000000
I 02209020
W 12 00001234 3
I 00000000
I 00000000
I 00129822
W 13 FFFFEDCC 3
// Test 4, double hazard on r20
I 20140001
W 14 00000001 4
I 20140002
W 14 00000002 4
I 0294A820
W 15 00000004 4
// Test 5, r0 as destination then read
I 20007FFF
I 0000B025
W 16 00000000 5
I 0000B820
W 17 00000000 5
// Test 6, dependent chain under random wait states
I 20180003
W 18 00000003 6
I 0318C020
W 18 00000006 6
I 0318C020
W 18 0000000C 6
I 0018C82A
W 19 00000001 6
I 0319D022
W 1a 0000000B 6
// Drain
I 00000000
I 00000000
I 00000000
